// ==== src/quplsPkg.sv ====
package quplsPkg;

	// ====================
	// Field widths
	// ====================

	// Opcode and function fields share one width
	localparam int OpcodeWidth = 7;
	// Each register specifier field in the instruction is six bits
	localparam int RegFieldWidth = 6;
	// Architectural register numbers carry regx above the six bit field
	localparam int AregWidth = RegFieldWidth + 1;

	// The MCB link flag sits in the top bit of the Rt field
	localparam int LkBit = 12;
	// Floating point targets only use the low five bits of the Rt field
	localparam int FltRtMsb = 11;
	localparam int FltRtLsb = 7;

	// ====================
	// Instruction word
	// ====================

	// Fields are declared from the most significant end down to the opcode
	typedef struct packed {
		logic [OpcodeWidth-1:0] func;
		logic [RegFieldWidth-1:0] rb;
		logic [RegFieldWidth-1:0] ra;
		logic [RegFieldWidth-1:0] rt;
		logic [OpcodeWidth-1:0] opcode;
	} instruction_t;

	// Reduced opcode subset, any value not listed is treated as undefined
	typedef enum logic [OpcodeWidth-1:0] {
		OP_R2 = 7'h02,
		OP_ADDI = 7'h04,
		OP_CSR = 7'h07,
		OP_ANDI = 7'h08,
		OP_ORI = 7'h09,
		OP_FLT2 = 7'h0C,
		OP_FLT3 = 7'h0D,
		OP_SHIFT = 7'h0E,
		OP_MOV = 7'h0F,
		OP_MCB = 7'h1C,
		OP_BSR = 7'h20,
		OP_JSR = 7'h21,
		OP_RTD = 7'h22,
		OP_DBRA = 7'h23,
		OP_LDB = 7'h40,
		OP_LDO = 7'h46,
		OP_STO = 7'h53
	} opcode_e;

	// Register to register functions that write a target
	typedef enum logic [OpcodeWidth-1:0] {
		FN_ADD = 7'h04,
		FN_SUB = 7'h05,
		FN_CMP = 7'h06,
		FN_AND = 7'h08,
		FN_OR = 7'h09,
		FN_EOR = 7'h0A,
		FN_MUL = 7'h0C,
		FN_SLT = 7'h13
	} func_e;

	typedef logic [AregWidth-1:0] aregno_t;

	// Implicit targets of the branch and loop instructions
	localparam aregno_t LinkReg = 7'd59;
	localparam aregno_t ReturnReg = 7'd63;
	localparam aregno_t LoopReg = 7'd55;

endpackage

// ==== src/quplsApbPkg.sv ====
package quplsApbPkg;

	// ====================
	// Bus geometry
	// ====================

	localparam int ApbAddrWidth = 4;
	localparam int ApbDataWidth = 32;

	// Word aligned register map of the decode unit
	typedef enum logic [ApbAddrWidth-1:0] {
		RegCtrl = 4'h0,
		RegInstr = 4'h4,
		RegResult = 4'h8,
		RegStatus = 4'hC
	} apbReg_e;

	// ====================
	// Result word layout
	// ====================

	// Each register number field is seven bits wide and byte aligned
	localparam int ResRtLsb = 0;
	localparam int ResRaLsb = 8;
	localparam int ResRbLsb = 16;
	localparam int ResDepABit = 24;
	localparam int ResDepBBit = 25;

	// STATUS reports the queue count in its low nibble
	localparam int StatusCountWidth = 4;

endpackage

// ==== src/quplsDecodeRt.sv ====
`timescale 1ns/1ps

module quplsDecodeRt (
	input quplsPkg::instruction_t instr,
	input logic regx,
	output quplsPkg::aregno_t Rt
);
	import quplsPkg::*;

	// Purely combinational, the decode stage registers the result
	always_comb
	begin
		case (opcode_e'(instr.opcode))
			// Only the listed R2 functions write a register
			OP_R2:
				case (func_e'(instr.func))
					FN_ADD, FN_SUB, FN_CMP, FN_MUL,
					FN_AND, FN_OR, FN_EOR, FN_SLT:
						Rt = {regx, instr.rt};
					default:
						Rt = '0;
				endcase
			// Float targets drop the top field bit and force a zero in its place
			OP_FLT2, OP_FLT3:
				Rt = {regx, 1'b0, instr[FltRtMsb:FltRtLsb]};
			// MCB writes the link register only when the link bit is set
			OP_MCB:
				Rt = instr[LkBit] ? LinkReg : '0;
			OP_RTD:
				Rt = ReturnReg;
			OP_DBRA:
				Rt = LoopReg;
			// Branch to subroutine and jump keep their return address in Rt
			OP_BSR, OP_JSR:
				Rt = {regx, instr.rt};
			// Immediate forms
			OP_ADDI, OP_ANDI, OP_ORI:
				Rt = {regx, instr.rt};
			OP_CSR, OP_MOV, OP_SHIFT:
				Rt = {regx, instr.rt};
			// Loads write the destination named in Rt
			OP_LDB, OP_LDO:
				Rt = {regx, instr.rt};
			// Stores have no target; undefined opcodes also fall here
			default:
				Rt = '0;
		endcase
	end

endmodule

// ==== src/quplsDecodeStage.sv ====
`timescale 1ns/1ps

module quplsDecodeStage (
	input logic clk,
	input logic reset,
	input logic launch,
	input quplsPkg::instruction_t instr,
	input logic regx,
	output logic decValid,
	output quplsPkg::aregno_t decRt,
	output quplsPkg::aregno_t decRa,
	output quplsPkg::aregno_t decRb
);
	import quplsPkg::*;

	aregno_t rtNext;
	aregno_t raNext;
	aregno_t rbNext;

	// Target register rule lives in its own block
	quplsDecodeRt decodeRt (
		.instr(instr),
		.regx(regx),
		.Rt(rtNext)
	);

	// Source registers, a zero means the operand is not a register
	always_comb
	begin
		case (opcode_e'(instr.opcode))
			OP_R2, OP_ADDI, OP_ANDI, OP_ORI, OP_SHIFT,
			OP_MOV, OP_LDB, OP_LDO, OP_STO:
				raNext = {regx, instr.ra};
			default:
				raNext = '0;
		endcase
		// Rb is the second operand of R2 and the store data of STO
		case (opcode_e'(instr.opcode))
			OP_R2, OP_STO:
				rbNext = {regx, instr.rb};
			default:
				rbNext = '0;
		endcase
	end

	// One cycle of latency, valid follows launch
	always_ff @(posedge clk)
	begin
		if (reset)
			decValid <= 1'b0;
		else
			decValid <= launch;
	end

	// Register numbers only load on a launch
	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			decRt <= rtNext;
			decRa <= raNext;
			decRb <= rbNext;
		end
	end

endmodule

// ==== src/quplsDependStage.sv ====
`timescale 1ns/1ps

module quplsDependStage #(
	parameter int HistDepth = 2
) (
	input logic clk,
	input logic reset,
	input logic decValid,
	input quplsPkg::aregno_t decRt,
	input quplsPkg::aregno_t decRa,
	input quplsPkg::aregno_t decRb,
	output logic resValid,
	output logic [quplsApbPkg::ApbDataWidth-1:0] resWord
);
	import quplsPkg::*;
	import quplsApbPkg::*;

	// Entry 0 holds the most recent target
	aregno_t hist [HistDepth];
	logic hitA;
	logic hitB;
	logic [ApbDataWidth-1:0] resNext;

	// Compare both sources against every history entry
	always_comb
	begin
		hitA = 1'b0;
		hitB = 1'b0;
		for (int i = 0; i < HistDepth; i++)
		begin
			if (hist[i] == decRa)
				hitA = 1'b1;
			if (hist[i] == decRb)
				hitB = 1'b1;
		end
		// Register 0 never creates a dependency
		resNext = '0;
		resNext[ResRtLsb +: AregWidth] = decRt;
		resNext[ResRaLsb +: AregWidth] = decRa;
		resNext[ResRbLsb +: AregWidth] = decRb;
		resNext[ResDepABit] = hitA && (decRa != '0);
		resNext[ResDepBBit] = hitB && (decRb != '0);
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			resValid <= 1'b0;
			for (int i = 0; i < HistDepth; i++)
				hist[i] <= '0;
		end
		else
		begin
			resValid <= decValid;
			// The current target joins the history after it has been checked
			if (decValid)
			begin
				hist[0] <= decRt;
				for (int i = 1; i < HistDepth; i++)
					hist[i] <= hist[i-1];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (decValid)
			resWord <= resNext;
	end

endmodule

// ==== src/quplsResultQueue.sv ====
`timescale 1ns/1ps

module quplsResultQueue #(
	parameter int QueueDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic [quplsApbPkg::ApbDataWidth-1:0] pushWord,
	input logic pop,
	output logic [quplsApbPkg::ApbDataWidth-1:0] head,
	output logic [$clog2(QueueDepth+1)-1:0] count
);
	import quplsApbPkg::*;

	// A single entry queue still needs a one bit pointer
	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int CountWidth = $clog2(QueueDepth + 1);

	logic [ApbDataWidth-1:0] mem [QueueDepth];
	logic [PtrWidth-1:0] wrPtr;
	logic [PtrWidth-1:0] rdPtr;
	logic doPush;
	logic doPop;

	// Pointers wrap at the depth, which need not be a power of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		nextPtr = (ptr == PtrWidth'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	// A full queue still accepts a push when the head leaves in the same cycle
	assign doPop = pop && (count != '0);
	assign doPush = push && ((count != CountWidth'(QueueDepth)) || doPop);
	assign head = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= nextPtr(wrPtr);
			if (doPop)
				rdPtr <= nextPtr(rdPtr);
			if (doPush && !doPop)
				count <= count + 1'b1;
			else if (doPop && !doPush)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushWord;
	end

endmodule

// ==== src/quplsApbSlave.sv ====
`timescale 1ns/1ps

module quplsApbSlave #(
	parameter int QueueDepth = 4
) (
	input logic clk,
	input logic reset,
	input logic [quplsApbPkg::ApbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [quplsApbPkg::ApbDataWidth-1:0] pwdata,
	output logic [quplsApbPkg::ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic launch,
	output quplsPkg::instruction_t instr,
	output logic regx,
	output logic pop,
	input logic [quplsApbPkg::ApbDataWidth-1:0] head,
	input logic [$clog2(QueueDepth+1)-1:0] count
);
	import quplsApbPkg::*;

	localparam int CountWidth = $clog2(QueueDepth + 1);

	// One credit per free queue slot, including results still in the stages
	logic [CountWidth-1:0] credits;
	logic accessPhase;
	logic xferDone;
	logic instrWrite;
	logic ctrlWrite;
	logic accessErr;

	// ====================
	// Transfer decode
	// ====================

	assign accessPhase = psel && penable;
	assign xferDone = accessPhase && pready;
	assign instrWrite = pwrite && (paddr == RegInstr);
	assign ctrlWrite = pwrite && (paddr == RegCtrl);
	// The head leaves the queue on the edge that completes a good RESULT read
	assign pop = xferDone && !pwrite && (paddr == RegResult) && (count != '0);
	assign pslverr = xferDone && accessErr;

	// Read data and error flag follow the address of the current access
	always_comb
	begin
		prdata = '0;
		accessErr = 1'b0;
		case (apbReg_e'(paddr))
			RegCtrl:
				prdata[0] = !pwrite && regx;
			RegInstr:
				if (!pwrite)
					prdata = instr;
			RegResult:
				if (pwrite || (count == '0))
					accessErr = 1'b1;
				else
					prdata = head;
			RegStatus:
				if (pwrite)
					accessErr = 1'b1;
				else
					prdata[StatusCountWidth-1:0] = StatusCountWidth'(count);
			default:
				accessErr = 1'b1;
		endcase
	end

	// ====================
	// Control registers
	// ====================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pready <= 1'b0;
			launch <= 1'b0;
			regx <= 1'b0;
			credits <= CountWidth'(QueueDepth);
		end
		else
		begin
			launch <= xferDone && instrWrite;
			// Raised from setup so reads finish in the first access cycle
			// INSTR writes wait here until a credit is free
			if (xferDone)
				pready <= 1'b0;
			else if (psel && !pready && (!instrWrite || (credits != '0)))
				pready <= 1'b1;
			if (xferDone && ctrlWrite)
				regx <= pwdata[0];
			if (xferDone && instrWrite && !pop)
				credits <= credits - 1'b1;
			else if (pop && !(xferDone && instrWrite))
				credits <= credits + 1'b1;
		end
	end

	// Instruction payload for the decode stage, held until the next write
	always_ff @(posedge clk)
	begin
		if (xferDone && instrWrite)
			instr <= pwdata;
	end

endmodule

// ==== src/quplsDecodeUnit.sv ====
`timescale 1ns/1ps

module quplsDecodeUnit #(
	parameter int QueueDepth = 4,
	parameter int HistDepth = 2
) (
	input logic clk,
	input logic reset,
	input logic [quplsApbPkg::ApbAddrWidth-1:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [quplsApbPkg::ApbDataWidth-1:0] pwdata,
	output logic [quplsApbPkg::ApbDataWidth-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import quplsPkg::*;
	import quplsApbPkg::*;

	localparam int CountWidth = $clog2(QueueDepth + 1);

	// Slave to decode stage
	logic launch;
	instruction_t instr;
	logic regx;
	// Decode stage to dependency stage
	logic decValid;
	aregno_t decRt;
	aregno_t decRa;
	aregno_t decRb;
	// Dependency stage to queue, and queue back to the slave
	logic resValid;
	logic [ApbDataWidth-1:0] resWord;
	logic [ApbDataWidth-1:0] head;
	logic [CountWidth-1:0] count;
	logic pop;

	quplsApbSlave #(
		.QueueDepth(QueueDepth)
	) apbSlave (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.launch(launch),
		.instr(instr),
		.regx(regx),
		.pop(pop),
		.head(head),
		.count(count)
	);

	quplsDecodeStage decodeStage (
		.clk(clk),
		.reset(reset),
		.launch(launch),
		.instr(instr),
		.regx(regx),
		.decValid(decValid),
		.decRt(decRt),
		.decRa(decRa),
		.decRb(decRb)
	);

	quplsDependStage #(
		.HistDepth(HistDepth)
	) dependStage (
		.clk(clk),
		.reset(reset),
		.decValid(decValid),
		.decRt(decRt),
		.decRa(decRa),
		.decRb(decRb),
		.resValid(resValid),
		.resWord(resWord)
	);

	quplsResultQueue #(
		.QueueDepth(QueueDepth)
	) resultQueue (
		.clk(clk),
		.reset(reset),
		.push(resValid),
		.pushWord(resWord),
		.pop(pop),
		.head(head),
		.count(count)
	);

endmodule

// ==== test/clockGen.sv ====
`timescale 1ns/1ps

module clockGen #(
	parameter int Period = 10,
	parameter int ResetCycles = 2
) (
	output logic clk,
	output logic reset
);

	// Free running clock, the first rising edge comes half a period in
	initial
	begin
		clk = 1'b0;
		forever
			#(Period / 2) clk = ~clk;
	end

	// Reset covers the first rising edges and drops on a falling edge
	initial
	begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

// ==== test/tbQuplsDecodeUnit.sv ====
`timescale 1ns/1ps

module tbQuplsDecodeUnit;
	import quplsPkg::*;
	import quplsApbPkg::*;

	localparam int ClockPeriod = 10;
	localparam int NumRandom = 200;
	// Upper bound on table and back-pressure instructions together
	localparam int DirectedInstrs = 40;
	localparam int CyclesPerInstr = 20;
	localparam int MarginCycles = 200;
	localparam int WatchdogCycles = (DirectedInstrs + NumRandom) * CyclesPerInstr + MarginCycles;

	// One directed case, the expected fields follow the result word layout
	typedef struct packed {
		logic regx;
		logic [31:0] instr;
		logic [6:0] rt;
		logic [6:0] ra;
		logic [6:0] rb;
		logic depA;
		logic depB;
	} vec_t;

	logic clk;
	logic reset;
	logic [3:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	vec_t vecs [$];
	string vecNames [$];
	logic [31:0] expQ [$];
	// Host side copy of regx and of the last two targets
	logic curRegx = 1'b0;
	logic [6:0] modelHist [2] = '{7'd0, 7'd0};
	logic [6:0] opPool [17] = '{OP_R2, OP_FLT2, OP_FLT3, OP_MCB, OP_BSR, OP_JSR, OP_RTD,
		OP_DBRA, OP_ADDI, OP_ANDI, OP_ORI, OP_CSR, OP_MOV, OP_SHIFT, OP_LDB, OP_LDO, OP_STO};
	logic [6:0] fnPool [8] = '{FN_ADD, FN_SUB, FN_CMP, FN_MUL, FN_AND, FN_OR, FN_EOR, FN_SLT};

	clockGen #(
		.Period(ClockPeriod),
		.ResetCycles(2)
	) clockGen (
		.clk(clk),
		.reset(reset)
	);

	quplsDecodeUnit #(
		.QueueDepth(4),
		.HistDepth(2)
	) UUT (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	// ====================
	// Reference model
	// ====================

	function automatic logic [6:0] refRt(input logic [31:0] ins, input logic rx);
		logic [6:0] op;
		logic [5:0] fld;
		op = ins[6:0];
		fld = ins[12:7];
		refRt = 7'd0;
		if (op == OP_R2)
		begin
			if (ins[31:25] inside {FN_ADD, FN_SUB, FN_CMP, FN_MUL, FN_AND, FN_OR, FN_EOR, FN_SLT})
				refRt = {rx, fld};
		end
		else if (op == OP_FLT2 || op == OP_FLT3)
			refRt = {rx, 1'b0, fld[4:0]};
		// The link bit is the top bit of the Rt field
		else if (op == OP_MCB)
			refRt = fld[5] ? 7'd59 : 7'd0;
		else if (op == OP_RTD)
			refRt = 7'd63;
		else if (op == OP_DBRA)
			refRt = 7'd55;
		else if (op inside {OP_BSR, OP_JSR, OP_ADDI, OP_ANDI, OP_ORI, OP_CSR, OP_MOV, OP_SHIFT,
			OP_LDB, OP_LDO})
			refRt = {rx, fld};
	endfunction

	function automatic logic [6:0] refRa(input logic [31:0] ins, input logic rx);
		if (ins[6:0] inside {OP_R2, OP_ADDI, OP_ANDI, OP_ORI, OP_SHIFT, OP_MOV, OP_LDB, OP_LDO,
			OP_STO})
			refRa = {rx, ins[18:13]};
		else
			refRa = 7'd0;
	endfunction

	function automatic logic [6:0] refRb(input logic [31:0] ins, input logic rx);
		refRb = (ins[6:0] inside {OP_R2, OP_STO}) ? {rx, ins[24:19]} : 7'd0;
	endfunction

	function automatic logic [31:0] packWord(input logic [6:0] rt, input logic [6:0] ra,
		input logic [6:0] rb, input logic dA, input logic dB);
		packWord = 32'd0;
		packWord[6:0] = rt;
		packWord[14:8] = ra;
		packWord[22:16] = rb;
		packWord[24] = dA;
		packWord[25] = dB;
	endfunction

	// Register 0 never counts as a producer
	function automatic logic hitsHist(input logic [6:0] src);
		hitsHist = (src != 7'd0) && (src == modelHist[0] || src == modelHist[1]);
	endfunction

	function automatic logic [31:0] modelWord(input logic [31:0] ins);
		logic [6:0] ra;
		logic [6:0] rb;
		ra = refRa(ins, curRegx);
		rb = refRb(ins, curRegx);
		modelWord = packWord(refRt(ins, curRegx), ra, rb, hitsHist(ra), hitsHist(rb));
	endfunction

	// ====================
	// APB host tasks
	// ====================

	// Entered and left on a falling edge, so every drive lands there
	task automatic apbXfer(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err, output int stalls);
		paddr = addr;
		pwrite = wr;
		pwdata = wdata;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		stalls = 0;
		#1;
		// The rising edge after pready is seen completes the transfer
		while (!pready)
		begin
			@(negedge clk);
			#1;
			stalls++;
		end
		rdata = prdata;
		err = pslverr;
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic setRegx(input logic rx);
		logic [31:0] rd;
		logic err;
		int st;
		apbXfer(1'b1, RegCtrl, {31'd0, rx}, rd, err, st);
		assert (!err) else failRun("CTRL write returned an error response");
		curRegx = rx;
	endtask

	// The history copy moves on only once the write has been accepted
	task automatic sendInstr(input logic [31:0] ins, input logic [31:0] expWord,
		output int stalls);
		logic [31:0] rd;
		logic err;
		apbXfer(1'b1, RegInstr, ins, rd, err, stalls);
		assert (!err) else failRun("INSTR write returned an error response");
		expQ.push_back(expWord);
		modelHist[1] = modelHist[0];
		modelHist[0] = refRt(ins, curRegx);
	endtask

	task automatic waitCount(input int want);
		logic [31:0] rd;
		logic err;
		int st;
		int tries;
		tries = 0;
		apbXfer(1'b0, RegStatus, 32'd0, rd, err, st);
		while (rd != want)
		begin
			tries++;
			assert (tries < 8) else failRun($sformatf("STATUS never reported a count of %0d", want));
			apbXfer(1'b0, RegStatus, 32'd0, rd, err, st);
		end
	endtask

	task automatic checkResult(input string name);
		logic [31:0] rd;
		logic [31:0] exp;
		logic err;
		int st;
		apbXfer(1'b0, RegResult, 32'd0, rd, err, st);
		assert (!err && st == 0) else failRun($sformatf("%s RESULT read failed or stalled", name));
		exp = expQ.pop_front();
		assert (rd == exp) else failRun($sformatf("MISMATCH %s expected %h got %h", name, exp, rd));
	endtask

	task automatic checkError(input string name, input logic [3:0] addr);
		logic [31:0] rd;
		logic err;
		int st;
		apbXfer(1'b0, addr, 32'd0, rd, err, st);
		assert (err) else failRun($sformatf("%s read completed without an error response", name));
		assert (rd == 32'd0) else failRun($sformatf("MISMATCH %s expected %h got %h", name, 32'd0, rd));
	endtask

	// ====================
	// Directed table
	// ====================

	task automatic addVec(input string name, input logic rx, input logic [6:0] op,
		input logic [6:0] fn, input logic [5:0] rt, input logic [5:0] ra, input logic [5:0] rb,
		input logic [6:0] eRt, input logic [6:0] eRa, input logic [6:0] eRb,
		input logic dA, input logic dB);
		vec_t v;
		v.regx = rx;
		v.instr = {fn, rb, ra, rt, op};
		v.rt = eRt;
		v.ra = eRa;
		v.rb = eRb;
		v.depA = dA;
		v.depB = dB;
		vecs.push_back(v);
		vecNames.push_back(name);
	endtask

	task automatic buildTable();
		// Target decode, sources kept clear of the recent targets
		addVec("r2AddX0", 0, OP_R2, FN_ADD, 20, 1, 2, 20, 1, 2, 0, 0);
		addVec("r2MulX1", 1, OP_R2, FN_MUL, 21, 3, 4, 85, 67, 68, 0, 0);
		addVec("r2BadFnX0", 0, OP_R2, 7'h7F, 22, 5, 6, 0, 5, 6, 0, 0);
		addVec("flt2X0", 0, OP_FLT2, 0, 6'h3A, 7, 8, 26, 0, 0, 0, 0);
		addVec("flt3X1", 1, OP_FLT3, 0, 6'h3A, 7, 8, 90, 0, 0, 0, 0);
		addVec("mcbLinkX0", 0, OP_MCB, 0, 6'h21, 0, 0, 59, 0, 0, 0, 0);
		addVec("mcbNoLinkX1", 1, OP_MCB, 0, 6'h1F, 0, 0, 0, 0, 0, 0, 0);
		addVec("rtdX0", 0, OP_RTD, 0, 9, 0, 0, 63, 0, 0, 0, 0);
		addVec("dbraX1", 1, OP_DBRA, 0, 9, 0, 0, 55, 0, 0, 0, 0);
		addVec("bsrX1", 1, OP_BSR, 0, 23, 0, 0, 87, 0, 0, 0, 0);
		addVec("jsrX0", 0, OP_JSR, 0, 24, 0, 0, 24, 0, 0, 0, 0);
		// Immediate, move, load and store classes check the source rules too
		addVec("addiX1", 1, OP_ADDI, 0, 25, 9, 10, 89, 73, 0, 0, 0);
		addVec("andiX0", 0, OP_ANDI, 0, 26, 11, 10, 26, 11, 0, 0, 0);
		addVec("oriX1", 1, OP_ORI, 0, 27, 12, 10, 91, 76, 0, 0, 0);
		addVec("csrX0", 0, OP_CSR, 0, 28, 13, 10, 28, 0, 0, 0, 0);
		addVec("movX1", 1, OP_MOV, 0, 29, 14, 10, 93, 78, 0, 0, 0);
		addVec("shiftX0", 0, OP_SHIFT, 0, 30, 15, 1, 30, 15, 0, 0, 0);
		addVec("ldbX1", 1, OP_LDB, 0, 31, 2, 1, 95, 66, 0, 0, 0);
		addVec("ldoX0", 0, OP_LDO, 0, 16, 3, 1, 16, 3, 0, 0, 0);
		addVec("stoX1", 1, OP_STO, 0, 17, 4, 5, 0, 68, 69, 0, 0);
		addVec("undefX0", 0, 7'h7E, 0, 18, 6, 7, 0, 0, 0, 0, 0);
		// History is all zero here, so the next two only seed it
		addVec("depSeed1", 0, OP_R2, FN_ADD, 40, 1, 2, 40, 1, 2, 0, 0);
		addVec("depSeed2", 0, OP_R2, FN_ADD, 41, 3, 4, 41, 3, 4, 0, 0);
		addVec("depHitBoth", 0, OP_R2, FN_ADD, 42, 40, 41, 42, 40, 41, 1, 1);
		addVec("depThreeBack", 0, OP_R2, FN_ADD, 43, 40, 42, 43, 40, 42, 0, 1);
		addVec("depZeroTarget", 0, OP_R2, FN_ADD, 0, 0, 43, 0, 0, 43, 0, 1);
		addVec("depZeroSource", 0, OP_R2, FN_ADD, 44, 0, 0, 44, 0, 0, 0, 0);
	endtask

	// Ends the run if the tests take longer than their worst case
	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		failRun("Watchdog expired before the tests finished");
	end

	initial
	begin
		logic [31:0] rd;
		logic err;
		int st;
		vec_t v;
		logic [31:0] ins;
		logic [31:0] bpInstr [5];
		logic [6:0] op;
		logic [6:0] fn;
		logic rx;
		int k;
		int j;
		paddr = 4'h0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		void'($urandom(19886));
		buildTable();
		@(negedge reset);
		@(negedge clk);

		// Queue starts empty and CTRL reads back regx
		waitCount(0);
		setRegx(1'b1);
		apbXfer(1'b0, RegCtrl, 32'd0, rd, err, st);
		assert (rd == 32'd1) else failRun($sformatf("MISMATCH ctrlRead expected %h got %h", 32'd1, rd));

		foreach (vecs[i])
		begin
			v = vecs[i];
			setRegx(v.regx);
			sendInstr(v.instr, packWord(v.rt, v.ra, v.rb, v.depA, v.depB), st);
			waitCount(1);
			checkResult(vecNames[i]);
		end

		// ====================
		// Back-pressure
		// ====================

		setRegx(1'b0);
		for (int i = 0; i < 5; i++)
			bpInstr[i] = {FN_OR, 6'(i + 2), 6'(i + 1), 6'(i + 10), OP_R2};
		for (int i = 0; i < 4; i++)
			sendInstr(bpInstr[i], modelWord(bpInstr[i]), st);
		waitCount(4);
		// With every credit taken the fifth write must not complete
		paddr = RegInstr;
		pwrite = 1'b1;
		pwdata = bpInstr[4];
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		repeat (6)
		begin
			#1;
			assert (!pready) else failRun("INSTR write completed with no free credit");
			@(negedge clk);
		end
		psel = 1'b0;
		penable = 1'b0;
		checkResult("bp0");
		sendInstr(bpInstr[4], modelWord(bpInstr[4]), st);
		assert (st == 0) else failRun("INSTR write still stalled after a result was read");
		waitCount(4);
		for (int i = 1; i < 5; i++)
			checkResult($sformatf("bp%0d", i));
		waitCount(0);

		checkError("emptyResult", RegResult);
		checkError("unmappedAddr", 4'h2);

		// ====================
		// Random instructions
		// ====================

		// Small register fields make dependencies frequent
		for (int i = 0; i < NumRandom; i++)
		begin
			k = $urandom % 20;
			j = $urandom % 8;
			op = (k < 17) ? opPool[k] : 7'($urandom);
			fn = (($urandom % 2) != 0) ? fnPool[j] : 7'($urandom);
			ins = {fn, 6'($urandom % 8), 6'($urandom % 8), 6'($urandom % 8), op};
			rx = 1'($urandom);
			if (rx != curRegx)
				setRegx(rx);
			sendInstr(ins, modelWord(ins), st);
			waitCount(1);
			checkResult($sformatf("rand%0d", i));
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== list.f ====
src/quplsPkg.sv
src/quplsApbPkg.sv
src/quplsDecodeRt.sv
src/quplsDecodeStage.sv
src/quplsDependStage.sv
src/quplsResultQueue.sv
src/quplsApbSlave.sv
src/quplsDecodeUnit.sv
test/clockGen.sv
test/tbQuplsDecodeUnit.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot change to the project root"
	exit 1
fi

verilator --binary --timing --assert --top-module tbQuplsDecodeUnit \
	-f list.f -Mdir obj_dir -o tbQuplsDecodeUnit
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tbQuplsDecodeUnit
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
